// File: include/ebox_config.svh
`ifndef EBOX_CONFIG_SVH
`define EBOX_CONFIG_SVH

// Full data word
`define EBOX_WORD_WIDTH 36

// AR is split into equal segments, segment 0 holds the leftmost bits
`define AR_SEGMENTS 4

// One AR segment
`define SEG_WIDTH 9

`endif

// File: rtl/cramPkg.sv
package cramPkg;

  // DISP field
  typedef enum logic [2:0] {
    dispNone   = 3'd0,
    dispAread  = 3'd1,
    dispReturn = 3'd2,
    dispNicond = 3'd3,
    dispMul    = 3'd4,
    dispDiv    = 3'd5,
    dispNorm   = 3'd6,
    dispEaMod  = 3'd7
  } dispT;

  // SPEC field
  typedef enum logic [3:0] {
    specNone      = 4'd0,
    specLoadPc    = 4'd1,
    specArlInd    = 4'd2,
    specAdLong    = 4'd3,
    specMqShift   = 4'd4,
    specSaveFlags = 4'd5,
    specInhCry18  = 4'd6
  } specT;

  // AR select field
  typedef enum logic [2:0] {
    arNone    = 3'd0,
    arAdAll   = 3'd1,
    arAdLeft  = 3'd2,
    arAdRight = 3'd3,
    arMem     = 3'd4,
    arEbus    = 3'd5,
    arClr     = 3'd6
  } arSelT;

  // COND field, only honored with condEn
  typedef enum logic [2:0] {
    condNone     = 3'd0,
    condArllLoad = 3'd1,
    condArlrLoad = 3'd2,
    condArrLoad  = 3'd3,
    condArClr    = 3'd4,
    condArlInd   = 3'd5,
    condRegCtl   = 3'd6
  } condT;

  typedef logic [8:0] magicT;

endpackage

// File: rtl/eboxPkg.sv
`include "ebox_config.svh"

package eboxPkg;

  typedef logic [`EBOX_WORD_WIDTH-1:0] wordT;

  typedef logic [`SEG_WIDTH-1:0] segT;

  // Where a loading segment takes its data from
  typedef enum logic [1:0] {
    srcAd   = 2'd0,
    srcMem  = 2'd1,
    srcEbus = 2'd2
  } segSrcT;

  // Console function code, bit 6 is the read flag
  typedef logic [6:0] diagSelT;

  // One bit per AR segment
  typedef logic [`AR_SEGMENTS-1:0] segMaskT;

endpackage

// File: rtl/ctlDecode.sv
`timescale 1ns/100ps
`include "ebox_config.svh"

module ctlDecode (
  input  logic              CTL,
  input  logic              arstN,
  input  cramPkg::dispT     crmDisp,
  input  cramPkg::specT     crmSpec,
  input  cramPkg::arSelT    crmAr,
  input  cramPkg::condT     crmCond,
  input  cramPkg::magicT    crmMagic,
  input  logic              condEn,
  input  logic              adBit18,
  input  logic              respMbox,
  input  eboxPkg::diagSelT  ebusDs,
  input  logic              diagStrobe,
  input  logic [4:0]        ebusCtlBits,
  output eboxPkg::segMaskT  segLoad,
  output eboxPkg::segMaskT  segClr,
  output eboxPkg::segSrcT   segSrc,
  output logic              adLong,
  output logic              loadPc,
  output logic [4:0]        diagCtlReg
);

  import cramPkg::*;
  import eboxPkg::*;

  localparam diagSelT funcLoadCtl = 7'o076;
  localparam diagSelT funcLoadAr  = 7'o077;

  localparam segMaskT leftHalfMask  = segMaskT'(4'b0011);
  localparam segMaskT rightHalfMask = segMaskT'(4'b1100);

  logic    diagArLoad;
  logic    diagCtlLoad;
  logic    arlInd;
  logic    shortEa;
  logic    arClrAll;
  segMaskT condLoad;

  // Console functions
  assign diagArLoad  = diagStrobe && (ebusDs == funcLoadAr);
  assign diagCtlLoad = diagStrobe && (ebusDs == funcLoadCtl);

  assign arlInd   = (crmSpec == specArlInd) || (condEn && crmCond == condArlInd);
  assign shortEa  = (crmDisp == dispEaMod) && adBit18;
  assign arClrAll = (crmAr == arClr) || (condEn && crmCond == condArClr);

  always_comb begin
    condLoad = '0;
    if (condEn) begin
      case (crmCond)
        condArllLoad: condLoad = segMaskT'(4'b0001);
        condArlrLoad: condLoad = segMaskT'(4'b0010);
        condArrLoad:  condLoad = rightHalfMask;
        default:      condLoad = '0;
      endcase
    end
  end

  always_comb begin
    segLoad = '0;
    segClr  = '0;
    segSrc  = srcAd;
    if (diagArLoad) begin
      // Console load overrides the microword
      segLoad = '1;
      segSrc  = srcEbus;
    end else begin
      if (arClrAll) begin
        segClr = '1;
      end
      if (shortEa) begin
        segClr |= leftHalfMask;
      end
      if (arlInd) begin
        // Magic field takes over the AR load strobes
        segLoad = segMaskT'(crmMagic[`AR_SEGMENTS-1:0]);
        if (crmMagic[4]) begin
          segClr |= leftHalfMask;
        end
      end else begin
        case (crmAr)
          arAdAll:   segLoad = '1;
          arAdLeft:  segLoad = leftHalfMask;
          arAdRight: segLoad = rightHalfMask;
          arMem: begin
            if (respMbox) begin
              segLoad = '1;
              segSrc  = srcMem;
            end
          end
          arEbus: begin
            segLoad = '1;
            segSrc  = srcEbus;
          end
          default: segLoad = '0;
        endcase
      end
      segLoad |= condLoad;
    end
  end

  assign adLong = (crmDisp == dispMul) || (crmDisp == dispDiv) ||
                  (crmDisp == dispNorm) || (crmSpec == specAdLong) ||
                  (crmSpec == specMqShift);

  assign loadPc = (crmSpec == specLoadPc) || (crmDisp == dispNicond);

  // Diagnostic control register, written by function 076
  always_ff @(posedge CTL or negedge arstN) begin
    if (!arstN) begin
      diagCtlReg <= '0;
    end else if (diagCtlLoad) begin
      diagCtlReg <= ebusCtlBits;
    end
  end

  // Memory data is only steered into AR while the MBOX responds
  assert property (@(posedge CTL) disable iff (!arstN)
    segSrc == srcMem |-> respMbox);

endmodule

// File: rtl/arSegment.sv
`timescale 1ns/100ps

module arSegment (
  input  logic             CTL,
  input  logic             arstN,
  input  logic             load,
  input  logic             clr,
  input  eboxPkg::segSrcT  src,
  input  eboxPkg::segT     adSeg,
  input  eboxPkg::segT     memSeg,
  input  eboxPkg::segT     ebusSeg,
  output eboxPkg::segT     seg,
  output logic             parOdd
);

  import eboxPkg::*;

  segT srcData;

  always_comb begin
    case (src)
      srcMem:  srcData = memSeg;
      srcEbus: srcData = ebusSeg;
      default: srcData = adSeg;
    endcase
  end

  // Clear wins over load, parity follows the data
  always_ff @(posedge CTL or negedge arstN) begin
    if (!arstN) begin
      seg    <= '0;
      parOdd <= 1'b0;
    end else if (clr) begin
      seg    <= '0;
      parOdd <= 1'b0;
    end else if (load) begin
      seg    <= srcData;
      parOdd <= ^srcData;
    end
  end

  // Decoder must settle the source before strobing a load
  assert property (@(posedge CTL) disable iff (!arstN)
    load |-> !$isunknown(src));

endmodule

// File: rtl/diagRead.sv
`timescale 1ns/100ps
`include "ebox_config.svh"

module diagRead (
  input  logic              CTL,
  input  logic              arstN,
  input  logic              diagRead,
  input  eboxPkg::diagSelT  ebusDs,
  input  eboxPkg::wordT     arWord,
  input  eboxPkg::segMaskT  parBits,
  input  eboxPkg::segMaskT  segLoad,
  input  eboxPkg::segMaskT  segClr,
  input  eboxPkg::segSrcT   segSrc,
  input  logic              adLong,
  input  logic              loadPc,
  input  logic [4:0]        diagCtlReg,
  output eboxPkg::wordT     diagData,
  output logic              diagDriving
);

  import eboxPkg::*;

  localparam int statusWidth = 3 * `AR_SEGMENTS + 4;

  logic                   readActive;
  logic [statusWidth-1:0] statusWord;
  wordT                   readWord;

  assign readActive = diagRead && ebusDs[6];

  // Low bit up: load mask, clear mask, source, adLong, loadPc, parity
  assign statusWord = {parBits, loadPc, adLong, segSrc, segClr, segLoad};

  always_comb begin
    case (ebusDs[5:3])
      3'b000:  readWord = arWord;
      3'b001:  readWord = wordT'(statusWord);
      3'b010:  readWord = wordT'(diagCtlReg);
      default: readWord = '0;
    endcase
  end

  always_ff @(posedge CTL or negedge arstN) begin
    if (!arstN) begin
      diagData    <= '0;
      diagDriving <= 1'b0;
    end else begin
      diagDriving <= readActive;
      // Bus is left at zero when nobody reads
      if (readActive) begin
        diagData <= readWord;
      end else begin
        diagData <= '0;
      end
    end
  end

endmodule

// File: rtl/eboxCtlTop.sv
`timescale 1ns/100ps
`include "ebox_config.svh"

module eboxCtlTop (
  input  logic              CTL,
  input  logic              arstN,
  input  cramPkg::dispT     crmDisp,
  input  cramPkg::specT     crmSpec,
  input  cramPkg::arSelT    crmAr,
  input  cramPkg::condT     crmCond,
  input  cramPkg::magicT    crmMagic,
  input  logic              condEn,
  input  eboxPkg::wordT     adResult,
  input  eboxPkg::wordT     mbData,
  input  logic              respMbox,
  input  eboxPkg::wordT     ebusData,
  input  eboxPkg::diagSelT  ebusDs,
  input  logic              diagStrobe,
  input  logic              diagRead,
  output eboxPkg::wordT     ar,
  output eboxPkg::segMaskT  arParOdd,
  output logic              adLong,
  output logic              loadPc,
  output eboxPkg::wordT     diagData,
  output logic              diagDriving
);

  import eboxPkg::*;

  segMaskT    segLoad;
  segMaskT    segClr;
  segSrcT     segSrc;
  logic [4:0] diagCtlReg;

  ctlDecode ctlDecode_i (
    .CTL         (CTL),
    .arstN       (arstN),
    .crmDisp     (crmDisp),
    .crmSpec     (crmSpec),
    .crmAr       (crmAr),
    .crmCond     (crmCond),
    .crmMagic    (crmMagic),
    .condEn      (condEn),
    .adBit18     (adResult[18]),
    .respMbox    (respMbox),
    .ebusDs      (ebusDs),
    .diagStrobe  (diagStrobe),
    .ebusCtlBits (ebusData[4:0]),
    .segLoad     (segLoad),
    .segClr      (segClr),
    .segSrc      (segSrc),
    .adLong      (adLong),
    .loadPc      (loadPc),
    .diagCtlReg  (diagCtlReg)
  );

  // Segment 0 sits in the leftmost bits of the word
  for (genvar i = 0; i < `AR_SEGMENTS; i++) begin : gSeg
    localparam int lsb = (`AR_SEGMENTS - 1 - i) * `SEG_WIDTH;

    arSegment arSegment_i (
      .CTL     (CTL),
      .arstN   (arstN),
      .load    (segLoad[i]),
      .clr     (segClr[i]),
      .src     (segSrc),
      .adSeg   (adResult[lsb +: `SEG_WIDTH]),
      .memSeg  (mbData[lsb +: `SEG_WIDTH]),
      .ebusSeg (ebusData[lsb +: `SEG_WIDTH]),
      .seg     (ar[lsb +: `SEG_WIDTH]),
      .parOdd  (arParOdd[i])
    );
  end

  diagRead diagRead_i (
    .CTL         (CTL),
    .arstN       (arstN),
    .diagRead    (diagRead),
    .ebusDs      (ebusDs),
    .arWord      (ar),
    .parBits     (arParOdd),
    .segLoad     (segLoad),
    .segClr      (segClr),
    .segSrc      (segSrc),
    .adLong      (adLong),
    .loadPc      (loadPc),
    .diagCtlReg  (diagCtlReg),
    .diagData    (diagData),
    .diagDriving (diagDriving)
  );

endmodule

// File: test/tbEboxCtl.sv
`timescale 1ns/100ps
`include "ebox_config.svh"

module tbEboxCtl;

  import cramPkg::*;
  import eboxPkg::*;

  // Rough cycle budget of all tests before the watchdog margin
  localparam int testCycles = 200;

  localparam diagSelT selArRead     = 7'o100;
  localparam diagSelT selStatusRead = 7'o110;
  localparam diagSelT selCtlRead    = 7'o120;
  localparam diagSelT selSpareRead  = 7'o130;

  logic       CTL;
  logic       arstN;
  dispT       crmDisp;
  specT       crmSpec;
  arSelT      crmAr;
  condT       crmCond;
  magicT      crmMagic;
  logic       condEn;
  wordT       adResult;
  wordT       mbData;
  logic       respMbox;
  wordT       ebusData;
  diagSelT    ebusDs;
  logic       diagStrobe;
  logic       diagRead;
  wordT       ar;
  segMaskT    arParOdd;
  logic       adLong;
  logic       loadPc;
  wordT       diagData;
  logic       diagDriving;

  wordT       expAr;
  int unsigned seedDummy;

  eboxCtlTop dut_i (
    .CTL         (CTL),
    .arstN       (arstN),
    .crmDisp     (crmDisp),
    .crmSpec     (crmSpec),
    .crmAr       (crmAr),
    .crmCond     (crmCond),
    .crmMagic    (crmMagic),
    .condEn      (condEn),
    .adResult    (adResult),
    .mbData      (mbData),
    .respMbox    (respMbox),
    .ebusData    (ebusData),
    .ebusDs      (ebusDs),
    .diagStrobe  (diagStrobe),
    .diagRead    (diagRead),
    .ar          (ar),
    .arParOdd    (arParOdd),
    .adLong      (adLong),
    .loadPc      (loadPc),
    .diagData    (diagData),
    .diagDriving (diagDriving)
  );

  always #5 CTL = ~CTL;

  initial begin
    #(testCycles * 10 + 1000);
    $display("Watchdog timeout: the tests did not finish in time");
    $display("TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

  function automatic wordT randWord();
    return wordT'({$urandom(), $urandom()});
  endfunction

  // Segment 0 is the leftmost group of bits
  function automatic segT segOf(wordT w, int i);
    return w[(`AR_SEGMENTS - 1 - i) * `SEG_WIDTH +: `SEG_WIDTH];
  endfunction

  function automatic segMaskT parityOf(wordT w);
    segMaskT p;
    for (int i = 0; i < `AR_SEGMENTS; i++) begin
      p[i] = ^segOf(w, i);
    end
    return p;
  endfunction

  function automatic wordT nextAr(wordT old, wordT data, segMaskT ldMask, segMaskT clMask);
    wordT result;
    int   lsb;
    result = old;
    for (int i = 0; i < `AR_SEGMENTS; i++) begin
      lsb = (`AR_SEGMENTS - 1 - i) * `SEG_WIDTH;
      if (clMask[i]) begin
        result[lsb +: `SEG_WIDTH] = '0;
      end else if (ldMask[i]) begin
        result[lsb +: `SEG_WIDTH] = data[lsb +: `SEG_WIDTH];
      end
    end
    return result;
  endfunction

  function automatic logic expectAdLong(dispT d, specT s);
    return d == dispMul || d == dispDiv || d == dispNorm ||
           s == specAdLong || s == specMqShift;
  endfunction

  function automatic logic expectLoadPc(dispT d, specT s);
    return s == specLoadPc || d == dispNicond;
  endfunction

  task automatic compareWord(string name, wordT actual, wordT expected);
    if (actual !== expected) begin
      $display("FAIL %0t %s: got %h expected %h", $time, name, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic compareMask(string name, segMaskT actual, segMaskT expected);
    if (actual !== expected) begin
      $display("FAIL %0t %s: got %b expected %b", $time, name, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "mask mismatch");
    end
  endtask

  task automatic compareBit(string name, logic actual, logic expected);
    if (actual !== expected) begin
      $display("FAIL %0t %s: got %b expected %b", $time, name, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "bit mismatch");
    end
  endtask

  task automatic setIdle();
    crmDisp    = dispNone;
    crmSpec    = specNone;
    crmAr      = arNone;
    crmCond    = condNone;
    crmMagic   = '0;
    condEn     = 1'b0;
    adResult   = '0;
    mbData     = '0;
    respMbox   = 1'b0;
    ebusData   = '0;
    ebusDs     = '0;
    diagStrobe = 1'b0;
    diagRead   = 1'b0;
  endtask

  // Returns on a falling edge ready to drive again
  task automatic stepEdge();
    @(posedge CTL);
    @(negedge CTL);
  endtask

  task automatic checkArState();
    compareWord("ar", ar, expAr);
    compareMask("arParOdd", arParOdd, parityOf(expAr));
  endtask

  // One microword with AD data and an AR check against the expected masks
  task automatic runAdStep(arSelT sel, wordT data, segMaskT ldMask, segMaskT clMask);
    crmAr    = sel;
    adResult = data;
    stepEdge();
    expAr = nextAr(expAr, data, ldMask, clMask);
    checkArState();
    setIdle();
  endtask

  task automatic testReset();
    compareWord("ar", ar, '0);
    compareMask("arParOdd", arParOdd, '0);
    compareWord("diagData", diagData, '0);
    compareBit("diagDriving", diagDriving, 1'b0);
    arstN = 1'b1;
    stepEdge();
    expAr = '0;
    checkArState();
    compareWord("diagData", diagData, '0);
    compareBit("diagDriving", diagDriving, 1'b0);
  endtask

  task automatic testArSelects();
    for (int n = 0; n < 4; n++) begin
      runAdStep(arAdAll, randWord(), 4'b1111, 4'b0000);
      runAdStep(arAdLeft, randWord(), 4'b0011, 4'b0000);
      runAdStep(arAdRight, randWord(), 4'b1100, 4'b0000);
      runAdStep(arClr, randWord(), 4'b0000, 4'b1111);
    end
  endtask

  task automatic testMemCond();
    wordT data;
    runAdStep(arAdAll, randWord(), 4'b1111, 4'b0000);
    // AR holds without an MBOX response
    crmAr  = arMem;
    mbData = randWord();
    stepEdge();
    checkArState();
    respMbox = 1'b1;
    data     = mbData;
    stepEdge();
    expAr = data;
    checkArState();
    setIdle();
    for (int en = 0; en < 2; en++) begin
      condEn  = en[0];
      crmCond = condArllLoad;
      runAdStep(arNone, randWord(), en ? 4'b0001 : 4'b0000, 4'b0000);
      condEn  = en[0];
      crmCond = condArlrLoad;
      runAdStep(arNone, randWord(), en ? 4'b0010 : 4'b0000, 4'b0000);
      condEn  = en[0];
      crmCond = condArrLoad;
      runAdStep(arNone, randWord(), en ? 4'b1100 : 4'b0000, 4'b0000);
      condEn  = en[0];
      crmCond = condArClr;
      runAdStep(arNone, randWord(), 4'b0000, en ? 4'b1111 : 4'b0000);
      runAdStep(arAdAll, randWord(), 4'b1111, 4'b0000);
    end
    // Short effective address with bit 18 set
    crmDisp = dispEaMod;
    runAdStep(arAdAll, randWord() | wordT'(1) << 18, 4'b1111, 4'b0011);
    crmDisp = dispEaMod;
    runAdStep(arAdRight, randWord() | wordT'(1) << 18, 4'b1100, 4'b0011);
    crmDisp = dispEaMod;
    runAdStep(arAdAll, randWord() & ~(wordT'(1) << 18), 4'b1111, 4'b0000);
  endtask

  task automatic testIndirect();
    logic clrLeft;
    for (int m = 0; m < 16; m++) begin
      clrLeft  = $urandom() % 2;
      crmSpec  = specArlInd;
      crmMagic = magicT'({clrLeft, m[3:0]});
      runAdStep(arAdAll, randWord(), segMaskT'(m), clrLeft ? 4'b0011 : 4'b0000);
    end
    // Same control through the condition field
    condEn   = 1'b1;
    crmCond  = condArlInd;
    crmMagic = 9'h01a;
    runAdStep(arAdRight, randWord(), 4'b1010, 4'b0011);
  endtask

  task automatic testDiagFunctions();
    wordT data;
    // Console AR load outranks a microword clear
    data       = randWord();
    crmAr      = arClr;
    diagStrobe = 1'b1;
    ebusDs     = 7'o077;
    ebusData   = data;
    stepEdge();
    expAr = data;
    checkArState();
    setIdle();
    data       = randWord();
    diagStrobe = 1'b1;
    ebusDs     = 7'o076;
    ebusData   = data;
    stepEdge();
    setIdle();
    checkArState();
    diagRead = 1'b1;
    ebusDs   = selCtlRead;
    stepEdge();
    compareWord("diagData", diagData, wordT'(data[4:0]));
    compareBit("diagDriving", diagDriving, 1'b1);
    setIdle();
  endtask

  task automatic readStatusCase(dispT d, specT s, arSelT sel, logic mbox, wordT data,
                                segMaskT ldMask, segMaskT clMask, segSrcT src);
    wordT    memData;
    wordT    expStatus;
    segMaskT oldPar;
    memData   = randWord();
    oldPar    = parityOf(expAr);
    expStatus = wordT'({oldPar, expectLoadPc(d, s), expectAdLong(d, s), src, clMask, ldMask});
    crmDisp   = d;
    crmSpec   = s;
    crmAr     = sel;
    respMbox  = mbox;
    adResult  = data;
    mbData    = memData;
    diagRead  = 1'b1;
    ebusDs    = selStatusRead;
    stepEdge();
    compareWord("diagData", diagData, expStatus);
    compareBit("diagDriving", diagDriving, 1'b1);
    expAr = nextAr(expAr, src == srcMem ? memData : data, ldMask, clMask);
    checkArState();
    setIdle();
  endtask

  task automatic testDiagReads();
    runAdStep(arAdAll, randWord(), 4'b1111, 4'b0000);
    diagRead = 1'b1;
    ebusDs   = selArRead;
    stepEdge();
    compareWord("diagData", diagData, expAr);
    compareBit("diagDriving", diagDriving, 1'b1);
    ebusDs = selSpareRead;
    stepEdge();
    compareWord("diagData", diagData, '0);
    // Read flag in bit 6 missing
    ebusDs = 7'o000;
    stepEdge();
    compareWord("diagData", diagData, '0);
    compareBit("diagDriving", diagDriving, 1'b0);
    setIdle();
    readStatusCase(dispMul, specNone, arAdLeft, 1'b0, randWord(), 4'b0011, 4'b0000, srcAd);
    readStatusCase(dispEaMod, specNone, arAdRight, 1'b0, randWord() | wordT'(1) << 18,
                   4'b1100, 4'b0011, srcAd);
    readStatusCase(dispNicond, specLoadPc, arMem, 1'b1, randWord(), 4'b1111, 4'b0000, srcMem);
    readStatusCase(dispNone, specAdLong, arClr, 1'b0, randWord(), 4'b0000, 4'b1111, srcAd);
    // Combinational decode of every dispatch and special code
    for (int d = 0; d < 8; d++) begin
      for (int s = 0; s < 7; s++) begin
        crmDisp = dispT'(d);
        crmSpec = specT'(s);
        #1;
        compareBit("adLong", adLong, expectAdLong(dispT'(d), specT'(s)));
        compareBit("loadPc", loadPc, expectLoadPc(dispT'(d), specT'(s)));
        @(negedge CTL);
      end
    end
    setIdle();
    stepEdge();
    checkArState();
  endtask

  initial begin
    seedDummy = $urandom(32'h81a5);
    CTL       = 1'b0;
    arstN     = 1'b0;
    expAr     = '0;
    setIdle();
    repeat (5) @(negedge CTL);
    testReset();
    testArSelects();
    testMemCond();
    testIndirect();
    testDiagFunctions();
    testDiagReads();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: all.f
+incdir+include
rtl/cramPkg.sv
rtl/eboxPkg.sv
rtl/ctlDecode.sv
rtl/arSegment.sv
rtl/diagRead.sv
rtl/eboxCtlTop.sv
test/tbEboxCtl.sv
